// ==== filelist.f ====
+incdir+include
verilog/dir_pkg.sv
verilog/dir_lfsr.sv
verilog/dir_victim_sel.sv
verilog/dir_tag_array.sv
verilog/dir_req_fifo.sv
verilog/dir_ctrl.sv
verilog/dir_top.sv
tb/dir_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cache directory testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module dir_tb -f filelist.f -o dir_tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/dir_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL TESTS PASSED" "$LOG"; then
    exit 0
fi
exit 1

// ==== include/dir_tb_model.svh ====
`ifndef DIR_TB_MODEL_SVH
`define DIR_TB_MODEL_SVH

// Reference copy of the array and LFSR state
logic [dir_pkg::TAG_W-1:0] mdl_tag   [dir_pkg::NUM_SETS][dir_pkg::NUM_WAYS];
logic                      mdl_valid [dir_pkg::NUM_SETS][dir_pkg::NUM_WAYS];
logic [15:0]               mdl_lfsr;     // Low mdl_lfsr_w bits live
int                        mdl_lfsr_w;
logic [31:0]               lcg_state;    // Stimulus generator

function automatic logic [15:0] mdl_poly(int w);
    case (w)
        8:       return 16'h00E1;
        9:       return 16'h01EA;
        10:      return 16'h02E3;
        11:      return 16'h04E3;
        12:      return 16'h0AE2;
        13:      return 16'h10E3;
        14:      return 16'h20EA;
        15:      return 16'h41E2;
        default: return 16'h81EE;
    endcase
endfunction

// Matches DUT reset, empty sets and all-ones LFSR
function automatic void mdl_reset(int w);
    mdl_lfsr_w = w;
    mdl_lfsr   = 16'hFFFF >> (16 - w);
    for (int s = 0; s < dir_pkg::NUM_SETS; s++) begin
        for (int k = 0; k < dir_pkg::NUM_WAYS; k++) begin
            mdl_valid[s][k] = 1'b0;
            mdl_tag[s][k]   = '0;
        end
    end
endfunction

function automatic void mdl_lfsr_shift();
    logic [15:0] nxt;
    nxt = mdl_lfsr >> 1;
    if (mdl_lfsr[0]) begin
        nxt = nxt ^ mdl_poly(mdl_lfsr_w);  // Taps fit inside the width
    end
    mdl_lfsr = nxt;
endfunction

function automatic void lcg_seed(logic [31:0] seed);
    lcg_state = seed;
endfunction

// Upper half has the better period
function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
endfunction

// Execute one request, return the expected response
function automatic dir_pkg::dir_rsp_t mdl_exec(dir_pkg::dir_req_t r);
    dir_pkg::dir_rsp_t         rsp;
    logic                      hit;
    logic                      found;
    logic [dir_pkg::WAY_W-1:0] way;
    rsp = '0;
    hit = 1'b0;
    way = '0;
    for (int k = dir_pkg::NUM_WAYS - 1; k >= 0; k--) begin
        if (mdl_valid[r.set][k] && (mdl_tag[r.set][k] == r.tag)) begin
            hit = 1'b1;
            way = k[dir_pkg::WAY_W-1:0];
        end
    end
    rsp.hit = hit;
    rsp.way = way;
    if ((r.op == dir_pkg::OP_ALLOC) && !hit) begin
        found = 1'b0;
        for (int k = 0; k < dir_pkg::NUM_WAYS; k++) begin
            if (!found && !mdl_valid[r.set][k]) begin
                found = 1'b1;
                way   = k[dir_pkg::WAY_W-1:0];
            end
        end
        if (!found) begin
            way = mdl_lfsr[dir_pkg::WAY_W-1:0];  // Random victim, then advance
            mdl_lfsr_shift();
        end
        rsp.way              = way;
        rsp.evict_valid      = mdl_valid[r.set][way];
        rsp.evict_tag        = mdl_valid[r.set][way] ? mdl_tag[r.set][way] : '0;
        mdl_valid[r.set][way] = 1'b1;
        mdl_tag[r.set][way]   = r.tag;
    end else if ((r.op == dir_pkg::OP_INVAL) && hit) begin
        mdl_valid[r.set][way] = 1'b0;
    end
    return rsp;
endfunction

`endif

// ==== tb/dir_tb.sv ====
`timescale 1ns/10ps

module dir_tb;
    import dir_pkg::*;

    localparam int LFSR_WIDTH   = 8;
    localparam int REQ_DEPTH    = 4;
    localparam int RSP_CREDITS  = 2;
    localparam int CLK_PERIOD   = 4;                          // ns
    localparam int RESET_CYCLES = 10;
    localparam int N_RANDOM     = 200;
    localparam int N_HOLD       = REQ_DEPTH + RSP_CREDITS;    // Fills pipe and queue
    localparam int N_TOTAL      = 16 + 8 + 6 + 4 + N_HOLD + N_RANDOM;

    logic     clk_i;
    logic     rst_ni;
    logic     req_valid;
    dir_req_t req;
    logic     req_credit;
    logic     rsp_valid;
    dir_rsp_t rsp;
    logic     rsp_credit;

    `include "dir_tb_model.svh"

    dir_rsp_t exp_q [$];            // Expected responses, request order
    string    name_q [$];
    int       due_q [$];            // Cycle each consumed response frees its credit
    int       req_credits;          // Request credits held
    int       pops_seen;            // Dequeues seen on req_credit
    int       credits_given;        // Pulses sent on rsp_credit
    int       ready_credits;
    int       rsp_count;
    int       sent;
    int       cycle;
    bit       hold_credits;         // Withhold response credits
    int       rsp_errors;
    int       credit_errors;
    int       proto_errors;

    dir_top #(
        .LFSR_WIDTH  (LFSR_WIDTH),
        .REQ_DEPTH   (REQ_DEPTH),
        .RSP_CREDITS (RSP_CREDITS)
    ) dir_top_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_credit (rsp_credit)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Budget of 40 cycles per request
    initial begin
        #((N_TOTAL * 40 + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout: responses still missing after %0d cycles",
                 N_TOTAL * 40 + RESET_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic check_rsp(input string name, input dir_rsp_t exp, input dir_rsp_t act);
        if (act !== exp) begin
            rsp_errors++;
            $display("error %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_credit(input string name, input int exp, input int act);
        if (act != exp) begin
            credit_errors++;
            $display("error %s: expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // Needs a request credit, model runs at send time
    task automatic send_req(input string name, input dir_req_t r);
        while (req_credits == 0) begin
            @(posedge clk_i);
            #1;
        end
        req       = r;
        req_valid = 1'b1;
        req_credits--;
        sent++;
        exp_q.push_back(mdl_exec(r));
        name_q.push_back($sformatf("%s #%0d", name, sent));
        @(posedge clk_i);
        #1;
        req_valid = 1'b0;
    endtask

    // All answered, every response credit handed back
    task automatic drain();
        while (exp_q.size() != 0 || credits_given != rsp_count) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // Small tag pool on four sets, so hits and evictions are common
    function automatic dir_req_t random_req();
        dir_req_t    rq;
        logic [15:0] r;
        r = lcg_next();
        case (r % 16'd3)
            16'd0:   rq.op = OP_LOOKUP;
            16'd1:   rq.op = OP_ALLOC;
            default: rq.op = OP_INVAL;
        endcase
        rq.set = {r[9:8], r[9:8]};                  // Sets 0, 5, 10, 15
        rq.tag = 12'hA00 + TAG_W'(r[15:12] % 4'd6);
        return rq;
    endfunction

    // Mid-cycle sampling of DUT outputs
    always @(negedge clk_i) begin
        dir_rsp_t    exp_rsp;
        string       exp_name;
        logic [15:0] r;
        int          due;
        if (rst_ni) begin
            if (req_credit && (RSP_CREDITS - pops_seen + credits_given) <= 0) begin
                proto_errors++;
                $display("request dequeued with no response credit left in the directory");
            end
            if (rsp_valid) begin
                if (exp_q.size() == 0) begin
                    proto_errors++;
                    $display("response arrived while no request was outstanding");
                end else begin
                    exp_rsp  = exp_q.pop_front();
                    exp_name = name_q.pop_front();
                    check_rsp(exp_name, exp_rsp, rsp);
                end
                rsp_count++;
                r   = lcg_next();
                due = cycle + 1 + int'(r % 16'd8);  // Random credit return delay
                if (due_q.size() > 0 && due < due_q[$]) begin
                    due = due_q[$];                 // Keep queue sorted
                end
                due_q.push_back(due);
            end
            if (req_credit) begin
                req_credits++;
                pops_seen++;
            end
            if (rsp_credit) begin
                credits_given++;
            end
        end
    end

    // Response credit return, one pulse per cycle
    initial begin
        rsp_credit = 1'b0;
        forever begin
            @(posedge clk_i);
            #1;
            cycle++;
            while (!hold_credits && due_q.size() > 0 && due_q[0] <= cycle) begin
                due_q.delete(0);
                ready_credits++;
            end
            rsp_credit = !hold_credits && (ready_credits > 0);
            if (rsp_credit) begin
                ready_credits--;
            end
        end
    end

    initial begin
        dir_req_t         rq;
        logic [15:0]      r;
        logic [TAG_W-1:0] tag;
        rst_ni        = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        hold_credits  = 1'b0;
        req_credits   = REQ_DEPTH;                 // Implicit at reset
        pops_seen     = 0;
        credits_given = 0;
        rsp_count     = 0;
        sent          = 0;
        rsp_errors    = 0;
        credit_errors = 0;
        proto_errors  = 0;
        lcg_seed(32'h67d3_6d7a);
        mdl_reset(LFSR_WIDTH);
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        for (int s = 0; s < NUM_SETS; s++) begin   // Empty after reset
            r      = lcg_next();
            rq.op  = OP_LOOKUP;
            rq.set = SET_W'(s);
            rq.tag = r[TAG_W-1:0];
            send_req("lookup_after_reset", rq);
        end

        rq.set = 4'd3;
        for (int k = 0; k < NUM_WAYS; k++) begin   // Ways 0 to 3 in order
            rq.op  = OP_ALLOC;
            rq.tag = 12'h100 + TAG_W'(k);
            send_req("alloc_fill", rq);
        end
        for (int k = 0; k < NUM_WAYS; k++) begin
            rq.op  = OP_LOOKUP;
            rq.tag = 12'h100 + TAG_W'(k);
            send_req("lookup_filled", rq);
        end

        for (int k = 0; k < 6; k++) begin           // Full set, LFSR victims
            rq.op  = OP_ALLOC;
            rq.tag = 12'h200 + TAG_W'(k);
            send_req("alloc_evict", rq);
        end

        tag    = mdl_tag[3][1];                     // Way 1 is valid here
        rq.op  = OP_INVAL;
        rq.tag = tag;
        send_req("inval_hit", rq);
        rq.op = OP_ALLOC;
        for (int k = 0; k < 3; k++) begin           // Reuse way 1, then LFSR resumes
            rq.tag = 12'h300 + TAG_W'(k);
            send_req("inval_reuse", rq);
        end
        drain();
        check_credit("credits_after_directed", REQ_DEPTH, req_credits);

        hold_credits = 1'b1;
        for (int k = 0; k < N_HOLD; k++) begin
            send_req("credit_hold", random_req());
        end
        idle(20);
        check_credit("hold_req_credits", 0, req_credits);
        check_credit("hold_outstanding", RSP_CREDITS, pops_seen - credits_given);
        check_credit("hold_queued", REQ_DEPTH, exp_q.size());
        hold_credits = 1'b0;
        drain();

        for (int k = 0; k < N_RANDOM; k++) begin
            send_req("random", random_req());
            r = lcg_next();
            idle(int'(r % 16'd3));                  // Gaps of 0 to 2 cycles
        end
        drain();
        check_credit("responses_received", sent, rsp_count);
        check_credit("final_req_credits", REQ_DEPTH, req_credits);

        $display("errors: response %0d, credit %0d, protocol %0d",
                 rsp_errors, credit_errors, proto_errors);
        if (rsp_errors + credit_errors + proto_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/dir_ctrl.sv ====
`timescale 1ns/10ps

module dir_ctrl #(
    parameter int RSP_CREDITS = 2
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  dir_pkg::dir_req_t         req,          // Queue head
    input  logic                      not_empty,
    output logic                      pop,
    output logic [dir_pkg::SET_W-1:0] set,
    input  dir_pkg::dir_ways_t        ways,         // Set read back
    input  logic [dir_pkg::WAY_W-1:0] victim_way,
    output logic                      alloc_miss,
    output logic                      wr_en,
    output logic [dir_pkg::WAY_W-1:0] wr_way,
    output logic                      wr_valid,
    output logic [dir_pkg::TAG_W-1:0] wr_tag,
    input  logic                      rsp_credit,   // Requester freed a slot
    output logic                      rsp_valid,
    output dir_pkg::dir_rsp_t         rsp
);
    import dir_pkg::*;

    localparam int CNT_W = $clog2(RSP_CREDITS + 1);

    logic [CNT_W-1:0] credit_q;                     // Response credits held
    logic             hit;
    logic [WAY_W-1:0] hit_way;
    dir_rsp_t         rsp_d;

    assign set = req.set;                           // Array indexed by head
    assign pop = not_empty && (credit_q != '0);     // Stall without credit

    // Tag compare, lowest way wins
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (ways[w].valid && (ways[w].tag == req.tag)) begin
                hit     = 1'b1;
                hit_way = WAY_W'(w);
            end
        end
    end

    // Operation decode, write port and response
    always_comb begin
        alloc_miss = 1'b0;
        wr_en      = 1'b0;
        wr_way     = hit_way;
        wr_valid   = 1'b0;
        wr_tag     = req.tag;
        rsp_d      = '0;
        rsp_d.hit  = hit;
        rsp_d.way  = hit ? hit_way : '0;            // Zero on plain miss
        case (req.op)
            OP_ALLOC: begin
                if (!hit) begin                     // Hit leaves the set alone
                    alloc_miss        = pop;
                    wr_en             = pop;
                    wr_way            = victim_way;
                    wr_valid          = 1'b1;
                    rsp_d.way         = victim_way;
                    rsp_d.evict_valid = ways[victim_way].valid;
                    rsp_d.evict_tag   = ways[victim_way].valid ? ways[victim_way].tag : '0;
                end
            end
            OP_INVAL: begin
                wr_en = pop && hit;                 // Clear only a matching way
            end
            default: begin
            end                                     // LOOKUP reads only
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            credit_q  <= CNT_W'(RSP_CREDITS);
            rsp_valid <= 1'b0;
        end else begin
            credit_q  <= credit_q + CNT_W'(rsp_credit) - CNT_W'(pop);
            rsp_valid <= pop;                       // One cycle after pop
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop) begin
            rsp <= rsp_d;
        end
    end

    // Requester returned more credits than it was given
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        credit_q <= CNT_W'(RSP_CREDITS))
    else $error("dir_ctrl: response credit count %0d above limit", credit_q);

endmodule

// ==== verilog/dir_lfsr.sv ====
`timescale 1ns/10ps

module dir_lfsr #(
    parameter int LFSR_WIDTH = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  shift,         // Advance one step
    output logic [LFSR_WIDTH-1:0] val
);

    // Maximal-length taps per width
    function automatic logic [15:0] poly_of(int w);
        case (w)
            8:       return 16'h00E1;
            9:       return 16'h01EA;
            10:      return 16'h02E3;
            11:      return 16'h04E3;
            12:      return 16'h0AE2;
            13:      return 16'h10E3;
            14:      return 16'h20EA;
            15:      return 16'h41E2;
            16:      return 16'h81EE;
            default: return 16'h0000;            // Rejected below
        endcase
    endfunction

    localparam logic [15:0] POLY = poly_of(LFSR_WIDTH);

    logic [LFSR_WIDTH-1:0] lfsr_q;
    logic [LFSR_WIDTH-1:0] lfsr_d;

    always_comb begin
        lfsr_d = lfsr_q >> 1;                    // Galois form shifts right
        if (lfsr_q[0]) begin
            lfsr_d = lfsr_d ^ POLY[LFSR_WIDTH-1:0];  // Feed back when LSB set
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lfsr_q <= '1;                        // Never the lock-up state
        end else if (shift) begin
            lfsr_q <= lfsr_d;
        end
    end

    assign val = lfsr_q;

    if ((LFSR_WIDTH < 8) || (LFSR_WIDTH > 16)) begin : gen_width_check
        $fatal(1, "dir_lfsr: LFSR_WIDTH must be 8 to 16");
    end

endmodule

// ==== verilog/dir_pkg.sv ====
package dir_pkg;

    localparam int SET_W    = 4;             // 16 sets
    localparam int NUM_SETS = 1 << SET_W;
    localparam int TAG_W    = 12;
    localparam int WAY_W    = 2;             // Way index
    localparam int NUM_WAYS = 4;

    // Requester operation codes
    typedef enum logic [1:0] {
        OP_LOOKUP = 2'd0,                    // Probe only
        OP_ALLOC  = 2'd1,                    // Install on miss
        OP_INVAL  = 2'd2                     // Clear matching way
    } dir_op_e;

    // 18-bit request
    typedef struct packed {
        dir_op_e          op;
        logic [SET_W-1:0] set;
        logic [TAG_W-1:0] tag;
    } dir_req_t;

    // 16-bit response
    typedef struct packed {
        logic             hit;
        logic [WAY_W-1:0] way;               // Hit way, filled way or zero
        logic             evict_valid;       // Fill displaced a valid tag
        logic [TAG_W-1:0] evict_tag;         // Zero unless evict_valid
    } dir_rsp_t;

    // One directory entry
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } dir_way_t;

    // Whole set, 52 bits
    typedef dir_way_t [NUM_WAYS-1:0] dir_ways_t;

endpackage

// ==== verilog/dir_req_fifo.sv ====
`timescale 1ns/10ps

module dir_req_fifo #(
    parameter int REQ_DEPTH = 4
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              push,       // Requester send, credit held
    input  dir_pkg::dir_req_t wdata,
    input  logic              pop,        // Also the returned credit
    output dir_pkg::dir_req_t rdata,      // Head entry
    output logic              not_empty
);
    import dir_pkg::*;

    localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(REQ_DEPTH + 1);

    dir_req_t         mem_q [REQ_DEPTH];  // Payload storage
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;            // Occupancy
    logic             full;

    // Wraps at REQ_DEPTH, any depth
    function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
        return (p == PTR_W'(REQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= wdata;     // Head visible next cycle
        end
    end

    assign rdata     = mem_q[rd_ptr_q];
    assign not_empty = (count_q != '0);
    assign full      = (count_q == CNT_W'(REQ_DEPTH));

    // Requester overran its credits
    assert property (@(posedge clk_i) disable iff (!rst_ni) !(push && full))
    else $error("dir_req_fifo: push into full queue, request credit violated");

    assert property (@(posedge clk_i) disable iff (!rst_ni) !(pop && !not_empty))
    else $error("dir_req_fifo: pop from empty queue");

endmodule

// ==== verilog/dir_tag_array.sv ====
`timescale 1ns/10ps

module dir_tag_array (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic [dir_pkg::SET_W-1:0] set,        // Read and write index
    output dir_pkg::dir_ways_t        ways,       // Combinational read
    input  logic                      wr_en,
    input  logic [dir_pkg::WAY_W-1:0] wr_way,
    input  logic                      wr_valid,
    input  logic [dir_pkg::TAG_W-1:0] wr_tag
);
    import dir_pkg::*;

    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];            // Cleared on reset
    logic [TAG_W-1:0]    tag_q   [NUM_SETS][NUM_WAYS];  // Payload only
    logic                dup_tag;

    // Valid bits
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (wr_en) begin
            valid_q[set][wr_way] <= wr_valid;           // Fill or invalidate
        end
    end

    // Tags
    always_ff @(posedge clk_i) begin
        if (wr_en && wr_valid) begin                    // INVAL keeps old tag
            tag_q[set][wr_way] <= wr_tag;
        end
    end

    // Whole set out
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            ways[w].valid = valid_q[set][w];
            ways[w].tag   = tag_q[set][w];
        end
    end

    // Same tag already valid in another way of this set
    always_comb begin
        dup_tag = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if ((WAY_W'(w) != wr_way) && valid_q[set][w] && (tag_q[set][w] == wr_tag)) begin
                dup_tag = 1'b1;
            end
        end
    end

    // Control only fills on a miss, so a set never holds a tag twice
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wr_en && wr_valid) |-> !dup_tag)
    else $error("dir_tag_array: fill duplicates a valid tag in set %0d", set);

endmodule

// ==== verilog/dir_top.sv ====
`timescale 1ns/10ps

module dir_top #(
    parameter int LFSR_WIDTH  = 8,            // 8 to 16
    parameter int REQ_DEPTH   = 4,            // Request credits at reset
    parameter int RSP_CREDITS = 2             // Response credits at reset
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              req_valid,
    input  dir_pkg::dir_req_t req,
    output logic              req_credit,     // Pulses once per dequeue
    output logic              rsp_valid,
    output dir_pkg::dir_rsp_t rsp,
    input  logic              rsp_credit
);
    import dir_pkg::*;

    dir_req_t              head_req;
    logic                  not_empty;
    logic [SET_W-1:0]      set;
    dir_ways_t             ways;
    logic [WAY_W-1:0]      victim_way;
    logic                  alloc_miss;
    logic                  wr_en;
    logic [WAY_W-1:0]      wr_way;
    logic                  wr_valid;
    logic [TAG_W-1:0]      wr_tag;
    logic [LFSR_WIDTH-1:0] lfsr_val;
    logic                  lfsr_shift;

    // Pop doubles as the request credit
    dir_req_fifo #(.REQ_DEPTH(REQ_DEPTH)) dir_req_fifo_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .push      (req_valid),
        .wdata     (req),
        .pop       (req_credit),
        .rdata     (head_req),
        .not_empty (not_empty)
    );

    dir_ctrl #(.RSP_CREDITS(RSP_CREDITS)) dir_ctrl_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .req        (head_req),
        .not_empty  (not_empty),
        .pop        (req_credit),
        .set        (set),
        .ways       (ways),
        .victim_way (victim_way),
        .alloc_miss (alloc_miss),
        .wr_en      (wr_en),
        .wr_way     (wr_way),
        .wr_valid   (wr_valid),
        .wr_tag     (wr_tag),
        .rsp_credit (rsp_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

    dir_tag_array dir_tag_array_i (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .set      (set),
        .ways     (ways),
        .wr_en    (wr_en),
        .wr_way   (wr_way),
        .wr_valid (wr_valid),
        .wr_tag   (wr_tag)
    );

    dir_victim_sel #(.LFSR_WIDTH(LFSR_WIDTH)) dir_victim_sel_i (
        .ways       (ways),
        .rnd        (lfsr_val),
        .alloc_miss (alloc_miss),
        .victim_way (victim_way),
        .shift      (lfsr_shift)
    );

    dir_lfsr #(.LFSR_WIDTH(LFSR_WIDTH)) dir_lfsr_i (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .shift  (lfsr_shift),
        .val    (lfsr_val)
    );

endmodule

// ==== verilog/dir_victim_sel.sv ====
`timescale 1ns/10ps

module dir_victim_sel #(
    parameter int LFSR_WIDTH = 8
) (
    input  dir_pkg::dir_ways_t        ways,        // Set being allocated
    input  logic [LFSR_WIDTH-1:0]     rnd,         // LFSR state
    input  logic                      alloc_miss,  // ALLOC missed this cycle
    output logic [dir_pkg::WAY_W-1:0] victim_way,
    output logic                      shift        // Consume random number
);
    import dir_pkg::*;

    logic [NUM_WAYS-1:0] valid_vec;
    logic                all_valid;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            valid_vec[w] = ways[w].valid;
        end
    end

    assign all_valid = &valid_vec;

    // Lowest invalid way first, random way when full
    always_comb begin
        victim_way = rnd[WAY_W-1:0];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_vec[w]) begin
                victim_way = WAY_W'(w);          // Lower index overrides
            end
        end
    end

    assign shift = alloc_miss && all_valid;      // Only a random pick advances LFSR

    // Fill lands on a free way whenever the set has one
    always_comb begin
        if (alloc_miss && !all_valid) begin
            assert (!valid_vec[victim_way])
            else $error("dir_victim_sel: victim way %0d valid while an invalid way exists",
                        victim_way);
        end
    end

    if (LFSR_WIDTH < WAY_W) begin : gen_rnd_check
        $fatal(1, "dir_victim_sel: LFSR narrower than way index");
    end

endmodule
